/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = tb_op_control
FILELIST = all.f
BUILD_DIR = obj_dir
LOG = sim.log

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

.PHONY: all build run lint clean

/* all.f */
hw/opl_pkg.sv
hw/chan_regs.sv
hw/slot_sequencer.sv
hw/slot_router.sv
hw/op_core.sv
hw/slot_mem.sv
hw/op_control.sv
bench/tb_op_control.sv

/* bench/tb_op_control.sv */
`default_nettype none

module tb_op_control
    import opl_pkg::*;
();
    localparam int clk_period = 40;
    localparam int drive_dly = 2;                  // inputs change shortly after the rising edge
    localparam int slot_cycles = pipeline_delay + 1;
    localparam int frame_cycles = num_slots * slot_cycles;
    localparam int tail_cycles = 20;
    localparam int mid_frame_cycle = 100;          // spurious sample strobe inside a frame
    localparam int num_rows = 5;
    localparam int watchdog_margin = 1000;
    localparam int wr_w = bank_w + reg_addr_w + $bits(chan_reg_t);
    localparam int sat_max = (1 << (op_out_w - 1)) - 1;
    localparam int sat_min = -(1 << (op_out_w - 1));

    logic clk;
    logic rst_n;
    logic sample_clk_en;
    logic reg_wr;
    logic [reg_addr_w-1:0] reg_addr;
    logic [bank_w-1:0] reg_bank;
    logic [$bits(chan_reg_t)-1:0] reg_data;
    logic out_valid;
    logic [bank_w-1:0] out_bank;
    logic [op_w-1:0] out_op;
    op_out_t out_value;

    // reference model state
    chan_reg_t model_cfg [num_banks][num_chans_per_bank];
    logic [num_pairs_per_bank-1:0] model_sel [num_banks];
    int model_last [num_banks][num_ops_per_bank];
    int model_prev [num_banks][num_ops_per_bank];
    int expected [num_slots];

    // stimulus table with one row per test
    string row_name [num_rows];
    int row_frames [num_rows];
    bit row_random [num_rows];
    int row_first [num_rows];
    int row_count [num_rows];
    logic [wr_w-1:0] wr_table [$];                 // {bank, addr, data}
    int cur_row = -1;
    bit table_ready = 1'b0;

    logic [15:0] lfsr_state = 16'd61;
    int value_errs = 0;
    int order_errs = 0;
    int timing_errs = 0;

    op_control dut_i (.clk, .rst_n, .sample_clk_en, .reg_wr, .reg_addr, .reg_bank, .reg_data,
                      .out_valid, .out_bank, .out_op, .out_value);

    always #(clk_period / 2) clk = ~clk;

    function automatic chan_reg_t chan_word(input int fnum, input int block, input bit kon,
                                            input int fb, input bit cnt);
        chan_reg_t w;
        w.fnum = fnum_w'(fnum);
        w.block = block_w'(block);
        w.kon = kon;
        w.fb = fb_w'(fb);
        w.cnt = cnt;
        return w;
    endfunction

    // taps for x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic int take_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            val = (val << 1) | int'(lfsr_state[0]);
        end
        return val;
    endfunction

    task automatic add_row(input string name, input int frames, input bit random);
        cur_row++;
        row_name[cur_row] = name;
        row_frames[cur_row] = frames;
        row_random[cur_row] = random;
        row_first[cur_row] = wr_table.size();
        row_count[cur_row] = 0;
    endtask

    task automatic add_write(input int bank, input int addr, input chan_reg_t data);
        wr_table.push_back({bank_w'(bank), reg_addr_w'(addr), data});
        row_count[cur_row]++;
    endtask

    task automatic add_sel_write(input int bank, input logic [num_pairs_per_bank-1:0] sel);
        add_write(bank, conn_sel_addr,
                  chan_reg_t'({{($bits(chan_reg_t) - num_pairs_per_bank){1'b0}}, sel}));
    endtask

    task automatic load_table();
        add_row("two_op_channels", 2, 1'b0);
        for (int c = 0; c < num_chans_per_bank; c++) begin
            add_write(0, c, chan_word(64 + 101 * c, c % 8, c != 4, 0, c[0]));
            add_write(1, c, chan_word(900 - 70 * c, 7 - c % 8, c != 7, 0, !c[0]));
        end
        add_row("feedback_levels", 4, 1'b0);
        for (int c = 0; c < num_chans_per_bank; c++) begin
            add_write(0, c, chan_word(700, 4, 1'b1, c % 8, 1'b0));
            add_write(1, c, chan_word(300 + 50 * c, 5, 1'b1, 7 - c % 8, 1'b1));
        end
        // bank 0 pairs get cnt 00, 01, 10 and bank 1 pair 1 gets 11
        add_row("four_op_pairs", 2, 1'b0);
        for (int c = 0; c < num_chans_per_bank; c++) begin
            add_write(0, c, chan_word(200 + 60 * c, 3 + c % 3, 1'b1, c % 3 + 1, c == 2 || c == 4));
            add_write(1, c, chan_word(150 + 75 * c, 2 + c % 4, 1'b1, c % 3 + 1, c == 1 || c == 4));
        end
        add_sel_write(0, 3'b111);
        add_sel_write(1, 3'b010);
        add_row("random_fnum", 2, 1'b1);
        add_sel_write(0, 3'b000);
        add_sel_write(1, 3'b000);
        add_row("saturation", 2, 1'b0);
        for (int c = 0; c < num_chans_per_bank; c++) begin
            add_write(0, c, chan_word(1023, 7, 1'b1, 7, 1'b0));
            add_write(1, c, chan_word(1023, 7, 1'b1, 7, 1'b0));
        end
        add_sel_write(0, 3'b101);
    endtask

    task automatic write_reg(input logic [wr_w-1:0] entry);
        @(posedge clk);
        #drive_dly;
        reg_wr = 1'b1;
        {reg_bank, reg_addr, reg_data} = entry;
        if (int'(reg_addr) < num_chans_per_bank)
            model_cfg[reg_bank][reg_addr] = reg_data;
        else if (int'(reg_addr) == conn_sel_addr)
            model_sel[reg_bank] = reg_data[num_pairs_per_bank-1:0];
    endtask

    task automatic end_writes();
        @(posedge clk);
        #drive_dly;
        reg_wr = 1'b0;
    endtask

    task automatic write_random_channels();
        int f;
        int blk;
        int fbv;
        int cn;
        for (int b = 0; b < num_banks; b++) begin
            for (int c = 0; c < num_chans_per_bank; c++) begin
                f = take_bits(fnum_w);
                blk = take_bits(block_w);
                fbv = take_bits(fb_w);
                cn = take_bits(1);
                write_reg({bank_w'(b), reg_addr_w'(c), chan_word(f, blk, 1'b1, fbv, cn[0])});
            end
        end
    endtask

    // expected output of every slot of the next frame in slot order
    task automatic predict_frame();
        int b;
        int o;
        int grp;
        int rel;
        int ch;
        int sum;
        bit modulator;
        bit use_mod;
        bit lo_cnt;
        bit hi_cnt;
        chan_reg_t cfg;
        for (int s = 0; s < num_slots; s++) begin
            b = s / num_ops_per_bank;
            o = s % num_ops_per_bank;
            grp = o / 3;
            rel = o % 3;
            ch = rel;
            modulator = 1'b0;
            use_mod = 1'b0;
            lo_cnt = model_cfg[b][rel].cnt;
            hi_cnt = model_cfg[b][rel + 3].cnt;
            case (grp)
                0: modulator = 1'b1;
                1: use_mod = !lo_cnt;
                2: begin
                    if (model_sel[b][rel]) begin
                        use_mod = !(!lo_cnt && hi_cnt);
                    end else begin
                        ch = rel + 3;
                        modulator = 1'b1;
                    end
                end
                3: begin
                    if (model_sel[b][rel]) begin
                        use_mod = !(lo_cnt && hi_cnt);
                    end else begin
                        ch = rel + 3;
                        use_mod = !hi_cnt;
                    end
                end
                4: begin
                    ch = rel + 6;
                    modulator = 1'b1;
                end
                default: begin
                    ch = rel + 6;
                    use_mod = !model_cfg[b][ch].cnt;
                end
            endcase
            cfg = model_cfg[b][ch];
            sum = (int'(cfg.fnum) << cfg.block) >> level_shift;
            if (use_mod)
                sum += model_last[b][o - mod_src_offset];  // this frame's output three back
            if (modulator && cfg.fb != 0)
                sum += (model_last[b][o] + model_prev[b][o]) >>> (9 - int'(cfg.fb));
            if (sum > sat_max)
                sum = sat_max;
            else if (sum < sat_min)
                sum = sat_min;
            if (!cfg.kon)
                sum = 0;
            expected[s] = sum;
            model_prev[b][o] = model_last[b][o];
            model_last[b][o] = sum;
        end
    endtask

    task automatic check_slot(input string name, input int k, input int n);
        int slot_b;
        int slot_o;
        slot_b = k / num_ops_per_bank;
        slot_o = k % num_ops_per_bank;
        if (n != (k + 1) * slot_cycles) begin
            $display("%s: slot strobe %0d came %0d cycles after the sample strobe instead of %0d",
                     name, k, n, (k + 1) * slot_cycles);
            timing_errs++;
        end
        if (int'(out_bank) != slot_b || int'(out_op) != slot_o) begin
            $display("Error %s: slot index expected %0d/%0d, actual %0d/%0d",
                     name, slot_b, slot_o, out_bank, out_op);
            order_errs++;
        end
        if (int'(out_value) != expected[k]) begin
            $display("Error %s: slot %0d/%0d value expected %0d, actual %0d",
                     name, slot_b, slot_o, expected[k], out_value);
            value_errs++;
        end
    endtask

    task automatic run_frame(input string name, input int frame);
        int seen;
        predict_frame();
        seen = 0;
        @(posedge clk);
        #drive_dly;
        sample_clk_en = 1'b1;
        for (int n = 1; n <= frame_cycles + tail_cycles; n++) begin
            @(posedge clk);
            #drive_dly;
            sample_clk_en = (n == mid_frame_cycle);
            @(negedge clk);
            if (out_valid) begin
                if (seen >= num_slots) begin
                    $display("%s: frame %0d gave an extra slot strobe %0d cycles after its start",
                             name, frame, n);
                    timing_errs++;
                end else begin
                    check_slot(name, seen, n);
                end
                seen++;
            end
        end
        if (seen < num_slots) begin
            $display("%s: frame %0d gave only %0d of %0d slot strobes", name, frame, seen,
                     num_slots);
            timing_errs++;
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (out_valid) begin
                $display("out_valid went high while no frame was running");
                timing_errs++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        sample_clk_en = 1'b0;
        reg_wr = 1'b0;
        reg_addr = '0;
        reg_bank = '0;
        reg_data = '0;
        for (int b = 0; b < num_banks; b++) begin
            model_sel[b] = '0;
            for (int c = 0; c < num_chans_per_bank; c++)
                model_cfg[b][c] = '0;
            for (int o = 0; o < num_ops_per_bank; o++) begin
                model_last[b][o] = 0;
                model_prev[b][o] = 0;
            end
        end
        load_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        #drive_dly;
        rst_n = 1'b1;
        check_idle(30);
        for (int r = 0; r < num_rows; r++) begin
            for (int i = 0; i < row_count[r]; i++) begin
                write_reg(wr_table[row_first[r] + i]);
            end
            if (row_random[r])
                write_random_channels();
            end_writes();
            for (int f = 0; f < row_frames[r]; f++) begin
                run_frame(row_name[r], f);
            end
        end
        $display("value errors %0d, slot order errors %0d, strobe errors %0d",
                 value_errs, order_errs, timing_errs);
        if (value_errs + order_errs + timing_errs == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // frame budget with room for reset and register writes
    initial begin
        int total_frames;
        wait (table_ready);
        total_frames = 0;
        for (int r = 0; r < num_rows; r++)
            total_frames += row_frames[r];
        #((total_frames * 260 + watchdog_margin) * clk_period);
        $display("watchdog expired with the tests still running");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/chan_regs.sv */
`default_nettype none

module chan_regs
    import opl_pkg::*;
(
    input wire clk,
    input wire rst_n,
    input wire reg_wr,
    input wire [reg_addr_w-1:0] reg_addr,
    input wire [bank_w-1:0] reg_bank,
    input wire [$bits(chan_reg_t)-1:0] reg_data,
    output chan_reg_t chan_cfg [num_banks][num_chans_per_bank],
    output logic [num_banks-1:0][num_pairs_per_bank-1:0] conn_sel
);
    logic chan_hit;  // address falls on one of the channel registers
    logic sel_hit;

    always_comb begin
        chan_hit = reg_addr < reg_addr_w'(num_chans_per_bank);
        sel_hit = reg_addr == reg_addr_w'(conn_sel_addr);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < num_banks; b++) begin
                for (int c = 0; c < num_chans_per_bank; c++) begin
                    chan_cfg[b][c] <= '0;
                end
            end
        end else if (reg_wr && chan_hit) begin
            for (int c = 0; c < num_chans_per_bank; c++) begin
                if (reg_addr == reg_addr_w'(c))
                    chan_cfg[reg_bank][c] <= reg_data;
            end
        end
    end

    // one select bit per 4-op pair, low bits of the data word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            conn_sel <= '0;
        end else if (reg_wr && sel_hit) begin
            conn_sel[reg_bank] <= reg_data[num_pairs_per_bank-1:0];
        end
    end

    // addresses 9..17 are silently dropped, anything past the select is a host bug
    wr_addr_range_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        reg_wr |-> reg_addr <= reg_addr_w'(conn_sel_addr)
    ) else $error("register write to unmapped address %0d", reg_addr);

endmodule

`default_nettype wire

/* hw/op_control.sv */
`default_nettype none

module op_control
    import opl_pkg::*;
(
    input wire clk,
    input wire rst_n,
    input wire sample_clk_en,
    input wire reg_wr,
    input wire [reg_addr_w-1:0] reg_addr,
    input wire [bank_w-1:0] reg_bank,
    input wire [$bits(chan_reg_t)-1:0] reg_data,
    output logic out_valid,
    output logic [bank_w-1:0] out_bank,
    output logic [op_w-1:0] out_op,
    output op_out_t out_value
);
    chan_reg_t chan_cfg [num_banks][num_chans_per_bank];
    logic [num_banks-1:0][num_pairs_per_bank-1:0] conn_sel;
    logic slot_start;
    logic busy;
    logic [bank_w-1:0] slot_bank;
    logic [op_w-1:0] slot_op;
    logic [fnum_w-1:0] fnum;
    logic [block_w-1:0] block;
    logic kon;
    logic [fb_w-1:0] fb;
    logic use_feedback;
    logic mod_en;
    logic [op_w-1:0] mod_addr;
    op_out_t mod_rd_data;
    fb_hist_t fb_rd_data;
    fb_hist_t fb_wr_data;
    logic [pipeline_delay:1][bank_w-1:0] bank_p;  // slot index riding beside the core
    logic [pipeline_delay:1][op_w-1:0] op_p;

    chan_regs chan_regs_i (.clk, .rst_n, .reg_wr, .reg_addr, .reg_bank, .reg_data,
                           .chan_cfg, .conn_sel);

    slot_sequencer seq_i (.clk, .rst_n, .sample_clk_en, .slot_start, .slot_bank,
                          .slot_op, .busy);

    slot_router router_i (.slot_bank, .slot_op, .chan_cfg, .conn_sel, .fnum, .block,
                          .kon, .fb, .use_feedback, .mod_en, .mod_addr);

    op_core core_i (.clk, .rst_n, .slot_start, .fnum, .block, .kon, .fb, .use_feedback,
                    .mod_en, .mod_value(mod_rd_data), .fb_hist(fb_rd_data),
                    .result_valid(out_valid), .result(out_value));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_p <= '0;
            op_p <= '0;
        end else begin
            bank_p <= {bank_p[pipeline_delay-1:1], slot_bank};
            op_p <= {op_p[pipeline_delay-1:1], slot_op};
        end
    end

    assign out_bank = bank_p[pipeline_delay];
    assign out_op = op_p[pipeline_delay];

    // fb history still holds this slot's read, so shift the new output in
    always_comb begin
        fb_wr_data.last = out_value;
        fb_wr_data.prev = fb_rd_data.last;
    end

    slot_mem #(.payload_t(op_out_t)) mod_mem_i (
        .clk, .rst_n, .wr_en(out_valid), .wr_bank(out_bank), .wr_addr(out_op),
        .wr_data(out_value), .rd_en(slot_start), .rd_bank(slot_bank), .rd_addr(mod_addr),
        .rd_data(mod_rd_data));

    slot_mem #(.payload_t(fb_hist_t)) fb_mem_i (
        .clk, .rst_n, .wr_en(out_valid), .wr_bank(out_bank), .wr_addr(out_op),
        .wr_data(fb_wr_data), .rd_en(slot_start), .rd_bank(slot_bank), .rd_addr(slot_op),
        .rd_data(fb_rd_data));

    // results only inside a frame, and exactly one core latency after their slot strobe
    out_timing_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> busy && $past(slot_start, pipeline_delay)
    ) else $error("out_valid not aligned with a slot strobe");

endmodule

`default_nettype wire

/* hw/op_core.sv */
`default_nettype none

module op_core
    import opl_pkg::*;
(
    input wire clk,
    input wire rst_n,
    input wire slot_start,
    input wire [fnum_w-1:0] fnum,
    input wire [block_w-1:0] block,
    input wire kon,
    input wire [fb_w-1:0] fb,
    input wire use_feedback,
    input wire mod_en,
    input wire op_out_t mod_value,
    input wire fb_hist_t fb_hist,
    output logic result_valid,
    output op_out_t result
);
    logic [pipeline_delay:1] vld;
    logic [fnum_w-1:0] s1_fnum, s2_fnum;
    logic [block_w-1:0] s1_block, s2_block;
    logic [fb_w-1:0] s1_fb, s2_fb, s3_fb;
    logic s1_kon, s2_kon, s3_kon, s4_kon, s5_kon;
    logic s1_use_fb, s1_mod_en;
    logic s2_fb_on, s3_fb_on;
    op_out_t s2_mod, s3_mod, s4_mod;
    fb_hist_t s2_hist, s3_hist;
    logic [base_w-1:0] s3_base, s4_base;
    logic [base_w+level_shift-1:0] shifted;
    logic signed [op_out_w:0] hist_sum;
    logic signed [op_out_w:0] s4_fb_term;
    logic signed [op_sum_w-1:0] s5_sum;
    op_out_t sat;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld <= '0;
            result <= '0;
        end else begin
            vld <= {vld[pipeline_delay-1:1], slot_start};
            if (vld[pipeline_delay-1])
                result <= s5_kon ? sat : '0;  // key off silences the slot
        end
    end

    always_comb begin
        shifted = (base_w + level_shift)'(s2_fnum) << s2_block;
        hist_sum = $signed({s3_hist.last[op_out_w-1], s3_hist.last})
                 + $signed({s3_hist.prev[op_out_w-1], s3_hist.prev});
        if (s5_sum > op_sum_w'(op_out_max))
            sat = op_out_t'(op_out_max);
        else if (s5_sum < op_sum_w'(op_out_min))
            sat = op_out_t'(op_out_min);
        else
            sat = op_out_t'(s5_sum);
    end

    always_ff @(posedge clk) begin
        if (slot_start) begin          // stage 1 captures the slot parameters
            s1_fnum <= fnum;
            s1_block <= block;
            s1_kon <= kon;
            s1_fb <= fb;
            s1_use_fb <= use_feedback;
            s1_mod_en <= mod_en;
        end
        if (vld[1]) begin              // stage 2 takes the memory data a cycle late
            s2_fnum <= s1_fnum;
            s2_block <= s1_block;
            s2_kon <= s1_kon;
            s2_fb <= s1_fb;
            s2_fb_on <= s1_use_fb && s1_fb != '0;
            s2_mod <= s1_mod_en ? mod_value : '0;
            s2_hist <= fb_hist;
        end
        s3_base <= base_w'(shifted >> level_shift);
        {s3_kon, s3_fb, s3_fb_on, s3_mod, s3_hist} <= {s2_kon, s2_fb, s2_fb_on, s2_mod, s2_hist};
        if (s3_fb_on)
            s4_fb_term <= hist_sum >>> (4'd9 - 4'(s3_fb));
        else
            s4_fb_term <= '0;
        {s4_kon, s4_base, s4_mod} <= {s3_kon, s3_base, s3_mod};
        s5_sum <= op_sum_w'($signed({1'b0, s4_base})) + op_sum_w'(s4_mod)
                + op_sum_w'(s4_fb_term);
        s5_kon <= s4_kon;
    end

    assign result_valid = vld[pipeline_delay];

endmodule

`default_nettype wire

/* hw/opl_pkg.sv */
`default_nettype none

package opl_pkg;
    localparam int num_banks = 2;
    localparam int num_ops_per_bank = 18;
    localparam int num_chans_per_bank = 9;
    localparam int num_pairs_per_bank = 3;
    localparam int pipeline_delay = 6;              // operator core latency
    localparam int num_slots = num_banks * num_ops_per_bank;

    localparam int bank_w = 1;
    localparam int op_w = 5;
    localparam int chan_w = $clog2(num_chans_per_bank);
    localparam int pair_w = $clog2(num_pairs_per_bank);
    localparam int state_w = $clog2(num_slots + 1);  // idle plus one state per slot
    localparam int dly_w = $clog2(pipeline_delay + 1);

    localparam int fnum_w = 10;
    localparam int block_w = 3;
    localparam int fb_w = 3;

    localparam int op_out_w = 13;
    localparam int op_out_max = 2 ** (op_out_w - 1) - 1;
    localparam int op_out_min = -(2 ** (op_out_w - 1));
    localparam int op_sum_w = op_out_w + 3;           // headroom for base + mod + feedback

    localparam int mod_src_offset = 3;
    localparam int level_shift = 5;
    // widest base level, fnum shifted by the largest block, minus the level shift
    localparam int base_w = fnum_w + (2 ** block_w - 1) - level_shift;

    localparam int reg_addr_w = 5;
    localparam int conn_sel_addr = 18;

    typedef logic signed [op_out_w-1:0] op_out_t;

    typedef struct packed {
        op_out_t last;  // most recent output of the slot
        op_out_t prev;  // the one before it
    } fb_hist_t;

    // register data layout, msb first
    typedef struct packed {
        logic [fnum_w-1:0] fnum;
        logic [block_w-1:0] block;
        logic kon;
        logic [fb_w-1:0] fb;
        logic cnt;
    } chan_reg_t;
endpackage

`default_nettype wire

/* hw/slot_mem.sv */
`default_nettype none

module slot_mem
    import opl_pkg::*;
#(
    parameter type payload_t = op_out_t
) (
    input wire clk,
    input wire rst_n,
    input wire wr_en,
    input wire [bank_w-1:0] wr_bank,
    input wire [op_w-1:0] wr_addr,
    input wire payload_t wr_data,
    input wire rd_en,
    input wire [bank_w-1:0] rd_bank,
    input wire [op_w-1:0] rd_addr,
    output payload_t rd_data
);
    payload_t mem [num_banks][num_ops_per_bank];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < num_banks; b++) begin
                for (int a = 0; a < num_ops_per_bank; a++) begin
                    mem[b][a] <= '0;
                end
            end
            rd_data <= '0;
        end else begin
            if (wr_en)
                mem[wr_bank][wr_addr] <= wr_data;
            if (rd_en)
                rd_data <= mem[rd_bank][rd_addr];  // held until the next read
        end
    end

    wr_addr_a: assert property (
        @(posedge clk) disable iff (!rst_n) wr_en |-> wr_addr < op_w'(num_ops_per_bank)
    ) else $error("slot memory write address %0d out of range", wr_addr);

    rd_addr_a: assert property (
        @(posedge clk) disable iff (!rst_n) rd_en |-> rd_addr < op_w'(num_ops_per_bank)
    ) else $error("slot memory read address %0d out of range", rd_addr);

endmodule

`default_nettype wire

/* hw/slot_router.sv */
`default_nettype none

module slot_router
    import opl_pkg::*;
(
    input wire [bank_w-1:0] slot_bank,
    input wire [op_w-1:0] slot_op,
    input wire chan_reg_t chan_cfg [num_banks][num_chans_per_bank],
    input wire [num_banks-1:0][num_pairs_per_bank-1:0] conn_sel,
    output logic [fnum_w-1:0] fnum,
    output logic [block_w-1:0] block,
    output logic kon,
    output logic [fb_w-1:0] fb,
    output logic use_feedback,
    output logic mod_en,
    output logic [op_w-1:0] mod_addr
);
    logic [2:0] grp;           // which run of three ops
    logic [pair_w-1:0] rel;    // position inside the run
    logic [chan_w-1:0] ch_idx;
    logic pair_on;
    logic is_mod;
    logic pair_lo;             // op 6+k of a 4-op pair
    logic pair_hi;             // op 9+k of a 4-op pair
    logic lo_cnt;
    logic hi_cnt;
    chan_reg_t cfg;

    always_comb begin
        grp = 3'd0;
        rel = pair_w'(slot_op);
        for (int g = 1; g < 6; g++) begin
            if (slot_op >= op_w'(3 * g)) begin
                grp = 3'(g);
                rel = pair_w'(slot_op - op_w'(3 * g));
            end
        end

        pair_on = conn_sel[slot_bank][rel];
        is_mod = 1'b0;
        pair_lo = 1'b0;
        pair_hi = 1'b0;
        ch_idx = chan_w'(rel);
        case (grp)
            3'd0: is_mod = 1'b1;                         // modulators of channels 0-2
            3'd2: begin
                if (pair_on) begin
                    pair_lo = 1'b1;
                end else begin
                    ch_idx = chan_w'(rel) + chan_w'(3);
                    is_mod = 1'b1;
                end
            end
            3'd3: begin
                if (pair_on)
                    pair_hi = 1'b1;
                else
                    ch_idx = chan_w'(rel) + chan_w'(3);
            end
            3'd4: begin
                ch_idx = chan_w'(rel) + chan_w'(6);
                is_mod = 1'b1;
            end
            3'd5: ch_idx = chan_w'(rel) + chan_w'(6);
            default: ch_idx = chan_w'(rel);              // carriers of channels 0-2
        endcase

        cfg = chan_cfg[slot_bank][ch_idx];
        lo_cnt = chan_cfg[slot_bank][chan_w'(rel)].cnt;
        hi_cnt = chan_cfg[slot_bank][chan_w'(rel) + chan_w'(3)].cnt;

        fnum = cfg.fnum;
        block = cfg.block;
        kon = cfg.kon;
        use_feedback = is_mod;
        fb = is_mod ? cfg.fb : '0;

        if (pair_lo)
            mod_en = !(!lo_cnt && hi_cnt);
        else if (pair_hi)
            mod_en = !(lo_cnt && hi_cnt);
        else
            mod_en = !is_mod && !cfg.cnt;   // 2-op carrier, fm unless additive

        // source slot three back, clamped at the bank start
        mod_addr = (slot_op >= op_w'(mod_src_offset)) ? slot_op - op_w'(mod_src_offset) : '0;
    end

endmodule

`default_nettype wire

/* hw/slot_sequencer.sv */
`default_nettype none

module slot_sequencer
    import opl_pkg::*;
(
    input wire clk,
    input wire rst_n,
    input wire sample_clk_en,
    output logic slot_start,
    output logic [bank_w-1:0] slot_bank,
    output logic [op_w-1:0] slot_op,
    output logic busy
);
    logic [state_w-1:0] state;    // 0 is idle, 1..36 are the slots
    logic [dly_w-1:0] dly_cnt;
    logic [state_w-1:0] idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= '0;
            dly_cnt <= '0;
        end else if (state == '0) begin
            dly_cnt <= '0;
            if (sample_clk_en)
                state <= state_w'(1);
        end else if (dly_cnt == dly_w'(pipeline_delay)) begin
            dly_cnt <= '0;
            state <= (state == state_w'(num_slots)) ? '0 : state + state_w'(1);
        end else begin
            dly_cnt <= dly_cnt + dly_w'(1);
        end
    end

    always_comb begin
        busy = state != '0;
        slot_start = busy && dly_cnt == '0;  // first cycle of each slot
        idx = state - state_w'(1);
        if (!busy) begin
            slot_bank = '0;
            slot_op = '0;
        end else if (idx >= state_w'(num_ops_per_bank)) begin
            slot_bank = bank_w'(1);
            slot_op = op_w'(idx - state_w'(num_ops_per_bank));
        end else begin
            slot_bank = '0;
            slot_op = op_w'(idx);
        end
    end

    // a slot only starts out of a running frame or right after an accepted strobe
    start_from_idle_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        slot_start |-> $past(busy) || $past(sample_clk_en)
    ) else $error("slot strobe fired while idle");

endmodule

`default_nettype wire
